//--- logic/zorro_defs.svh
// bus and card constants; config offsets are byte offsets, and the card claims a 64MB window
`ifndef ZORRO_DEFS_SVH
`define ZORRO_DEFS_SVH

// --------------------
// widths
// --------------------
`define ZORRO_ADDR_W 32
`define ZORRO_DATA_W 32
// 1024 words of local ram, mirrored over the whole card window
`define ZORRO_RAM_AW 10

// --------------------
// address map
// --------------------
// upper half-word of zorro iii config space
`define ZORRO_CFG_BASE 16'hFF00
// 64MB card space, compare A31..A26 only
`define ZORRO_CARD_MSB 31
`define ZORRO_CARD_LSB 26
// base address write, A31..A16 on D31..D16
`define ZORRO_REG_BASE 8'h44
// any write here retires the card from the chain
`define ZORRO_REG_SHUTUP 8'h4C

// --------------------
// cycle timing in clk periods
// --------------------
`define ZORRO_DTACK_DELAY 2
`define ZORRO_DTACK_TIMEOUT 48
`define ZORRO_RAM_LATENCY 2

`endif

//--- logic/zorro_bus_pkg.sv
// bus-side types; address and data are logical 32-bit words, lane mapping lives in the pad ring
`default_nettype none

`include "zorro_defs.svh"

package zorro_bus_pkg;

	// address latched on full-cycle strobe
	typedef logic [`ZORRO_ADDR_W-1:0] zaddr_t;
	// data word, D31..D0
	typedef logic [`ZORRO_DATA_W-1:0] zdata_t;
	// active-low data strobes, bit 3 strobes D31..D24
	typedef logic [3:0] zstrobe_t;
	// local ram word index
	typedef logic [`ZORRO_RAM_AW-1:0] ram_addr_t;

	// slave cycle states
	typedef enum logic [3:0] {
		cs_idle,
		cs_match,
		cs_data_phase,
		cs_write_strobe,
		cs_write_wait,
		cs_read_wait,
		cs_dtack_delay,
		cs_dtack,
		cs_dtack_err
	} cycle_state_t;

endpackage

`default_nettype wire

//--- logic/zorro_cfg_pkg.sv
// autoconfig types and rom; rom ids are placeholders, type register is read back uninverted
`default_nettype none

package zorro_cfg_pkg;

	typedef logic [3:0] cfg_nibble_t;
	// address bits 8:2, bit 6 picks the low nibble half at +$100
	typedef logic [6:0] cfg_offset_t;
	// assigned base, A31..A16
	typedef logic [15:0] card_base_t;

	// --------------------
	// rom contents
	// --------------------
	// zorro iii, not linked into the pool, size code 010
	localparam logic [7:0] rom_type = 8'h82;
	localparam logic [7:0] rom_product = 8'h3C;
	// extended size (64MB with code 010), z3 reserved bit set
	localparam logic [7:0] rom_flags = 8'h30;
	localparam logic [15:0] rom_maker = 16'h0F1E;
	localparam logic [31:0] rom_serial = 32'h0000_0001;

	function automatic cfg_nibble_t cfg_rom_nibble(input cfg_offset_t off);
		logic [7:0] val;
		// register index is byte offset / 4
		case (off[5:0])
			6'h00: val = rom_type;
			6'h01: val = rom_product;
			6'h02: val = rom_flags;
			6'h04: val = rom_maker[15:8];
			6'h05: val = rom_maker[7:0];
			6'h06: val = rom_serial[31:24];
			6'h07: val = rom_serial[23:16];
			6'h08: val = rom_serial[15:8];
			6'h09: val = rom_serial[7:0];
			default: val = 8'h00;
		endcase
		// everything past er_type goes out inverted
		if (off[5:0] != 6'h00)
			val = ~val;
		return off[6] ? val[3:0] : val[7:4];
	endfunction

endpackage

`default_nettype wire

//--- logic/bus_capture.sv
// address is sampled on clk, so the master must hold AD for three clocks after nfcs falls
`default_nettype none
`timescale 1ns/10ps

`include "zorro_defs.svh"

module bus_capture import zorro_bus_pkg::*, zorro_cfg_pkg::*; (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic doe_i,
	input zstrobe_t nds_i,
	input logic [1:0] fc_i,
	input logic [23:0] ad_i,
	input logic [5:0] a_i,
	input logic cfgin_n_i,
	input logic configured_i,
	input card_base_t card_base_i,
	output logic fcs_n_o,
	output logic doe_o,
	output zstrobe_t nds_o,
	output zaddr_t addr_o,
	output logic cfg_hit_o,
	output logic card_hit_o
);

	// --------------------
	// synchronizers
	// --------------------
	logic [1:0] fcs_sync;
	logic [1:0] doe_sync;
	zstrobe_t nds_s1;
	zstrobe_t nds_s2;
	// previous synced fcs, for the falling edge
	logic fcs_prev;
	// address valid, decode next clock
	logic cap_q;
	logic fcs_start;
	logic space_ok;

	assign fcs_start = !fcs_sync[1] && fcs_prev;
	// only fc 01 and 10 are user/supervisor data or program space
	assign space_ok = fc_i[0] ^ fc_i[1];

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			fcs_sync <= 2'b11;
			doe_sync <= 2'b00;
			nds_s1 <= '1;
			nds_s2 <= '1;
			fcs_prev <= 1'b1;
			cap_q <= 1'b0;
		end else begin
			fcs_sync <= {fcs_sync[0], nfcs_i};
			doe_sync <= {doe_sync[0], doe_i};
			nds_s1 <= nds_i;
			nds_s2 <= nds_s1;
			fcs_prev <= fcs_sync[1];
			cap_q <= fcs_start;
		end
	end

	// A31..A8 multiplexed, A7..A2 static
	always_ff @(posedge clk) begin
		if (fcs_start)
			addr_o <= {ad_i, a_i, 2'b00};
	end

	// --------------------
	// registered decode
	// --------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			cfg_hit_o <= 1'b0;
			card_hit_o <= 1'b0;
		end else if (fcs_sync[1]) begin
			cfg_hit_o <= 1'b0;
			card_hit_o <= 1'b0;
		end else if (cap_q) begin
			// config space only while our chain input is asserted
			cfg_hit_o <= space_ok && (addr_o[31:16] == `ZORRO_CFG_BASE) &&
				!cfgin_n_i && !configured_i;
			card_hit_o <= space_ok && configured_i &&
				(addr_o[`ZORRO_CARD_MSB:`ZORRO_CARD_LSB] ==
				card_base_i[`ZORRO_CARD_MSB-16:`ZORRO_CARD_LSB-16]);
		end
	end

	assign fcs_n_o = fcs_sync[1];
	assign doe_o = doe_sync[1];
	assign nds_o = nds_s2;

endmodule

`default_nettype wire

//--- logic/cycle_ctrl.sv
// single full cycles only, no multiple-transfer handshake; config writes take one clock
`default_nettype none
`timescale 1ns/10ps

`include "zorro_defs.svh"

module cycle_ctrl import zorro_bus_pkg::*, zorro_cfg_pkg::*; (
	input logic clk,
	input logic nIORST,
	input logic fcs_n_i,
	input logic doe_i,
	input zstrobe_t nds_i,
	input logic read_i,
	input logic nberr_i,
	input logic cfg_hit_i,
	input logic card_hit_i,
	input zaddr_t addr_i,
	input zdata_t data_i,
	input logic ram_ack_i,
	input zdata_t ram_rdata_i,
	input cfg_nibble_t cfg_rdata_i,
	output logic slave_n_o,
	output logic dtack_n_o,
	output zdata_t data_o,
	output logic data_oe_o,
	output logic ram_stb_o,
	output logic ram_we_o,
	output logic [3:0] ram_be_o,
	output ram_addr_t ram_addr_o,
	output zdata_t ram_wdata_o,
	output logic cfg_wr_o,
	output logic [15:0] cfg_wdata_o,
	output cfg_offset_t cfg_offset_o
);

	localparam int CNT_W = $clog2(`ZORRO_DTACK_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] DELAY_LAST = CNT_W'(`ZORRO_DTACK_DELAY - 1);
	localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(`ZORRO_DTACK_TIMEOUT - 1);

	cycle_state_t state_q;
	// dtack delay and dtack timeout share one counter
	logic [CNT_W-1:0] cnt_q;

	// --------------------
	// cycle fsm
	// --------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q <= cs_idle;
			cnt_q <= '0;
			slave_n_o <= 1'b1;
			dtack_n_o <= 1'b1;
			ram_stb_o <= 1'b0;
			ram_we_o <= 1'b0;
			cfg_wr_o <= 1'b0;
		end else if (fcs_n_i) begin
			// master ended the cycle, let go of everything
			state_q <= cs_idle;
			slave_n_o <= 1'b1;
			dtack_n_o <= 1'b1;
			ram_stb_o <= 1'b0;
			cfg_wr_o <= 1'b0;
		end else begin
			case (state_q)
				cs_idle: begin
					if (cfg_hit_i || card_hit_i) begin
						slave_n_o <= 1'b0;
						state_q <= cs_match;
					end
				end
				cs_match: begin
					if (doe_i)
						state_q <= cs_data_phase;
				end
				cs_data_phase: begin
					if (read_i) begin
						// config read needs no ram access
						if (cfg_hit_i) begin
							cnt_q <= '0;
							state_q <= cs_dtack_delay;
						end else begin
							ram_stb_o <= 1'b1;
							ram_we_o <= 1'b0;
							state_q <= cs_read_wait;
						end
					end else if (nds_i != 4'hF) begin
						state_q <= cs_write_strobe;
					end
				end
				cs_write_strobe: begin
					if (cfg_hit_i) begin
						cfg_wr_o <= 1'b1;
					end else begin
						ram_stb_o <= 1'b1;
						ram_we_o <= 1'b1;
					end
					state_q <= cs_write_wait;
				end
				cs_write_wait: begin
					// config write pulse is done in one clock
					if (cfg_wr_o || ram_ack_i) begin
						cfg_wr_o <= 1'b0;
						ram_stb_o <= 1'b0;
						dtack_n_o <= 1'b0;
						cnt_q <= '0;
						state_q <= cs_dtack;
					end
				end
				cs_read_wait: begin
					if (ram_ack_i) begin
						ram_stb_o <= 1'b0;
						cnt_q <= '0;
						state_q <= cs_dtack_delay;
					end
				end
				cs_dtack_delay: begin
					// give the data bus time to settle
					if (cnt_q == DELAY_LAST) begin
						dtack_n_o <= 1'b0;
						cnt_q <= '0;
						state_q <= cs_dtack;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				cs_dtack: begin
					if (cnt_q == TIMEOUT_LAST) begin
						dtack_n_o <= 1'b1;
						state_q <= cs_dtack_err;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				// parked until nfcs goes high
				cs_dtack_err: ;
				default: state_q <= cs_idle;
			endcase
		end
	end

	// --------------------
	// data path
	// --------------------
	always_ff @(posedge clk) begin
		if (state_q == cs_data_phase && read_i && cfg_hit_i)
			data_o <= {cfg_rdata_i, 28'hFFF_FFFF};
		if (state_q == cs_read_wait && ram_ack_i)
			data_o <= ram_rdata_i;
		// reads always fetch the full word
		if (state_q == cs_data_phase && read_i)
			ram_be_o <= 4'hF;
		if (state_q == cs_write_strobe) begin
			ram_wdata_o <= data_i;
			ram_be_o <= ~nds_i;
		end
	end

	// base register comes in on D31..D16
	assign cfg_wdata_o = ram_wdata_o[31:16];
	assign cfg_offset_o = addr_i[8:2];
	// card window mirrors the small ram
	assign ram_addr_o = addr_i[`ZORRO_RAM_AW+1:2];

	// off at once on bus error
	assign data_oe_o = read_i && nberr_i &&
		(state_q == cs_dtack_delay || state_q == cs_dtack);

endmodule

`default_nettype wire

//--- logic/autoconfig.sv
// config offsets follow the zorro iii layout; shut-up and configuration both pass the chain on
`default_nettype none
`timescale 1ns/10ps

`include "zorro_defs.svh"

module autoconfig import zorro_cfg_pkg::*; (
	input logic clk,
	input logic nIORST,
	input logic cfg_wr_i,
	input cfg_offset_t cfg_offset_i,
	input logic [15:0] cfg_wdata_i,
	output cfg_nibble_t cfg_rdata_o,
	output logic configured_o,
	output card_base_t card_base_o,
	output logic cfgout_n_o
);

	localparam cfg_offset_t OFF_BASE = cfg_offset_t'(`ZORRO_REG_BASE >> 2);
	localparam cfg_offset_t OFF_SHUTUP = cfg_offset_t'(`ZORRO_REG_SHUTUP >> 2);

	logic shutup_q;
	logic base_wr;
	logic shutup_wr;

	assign base_wr = cfg_wr_i && (cfg_offset_i == OFF_BASE);
	assign shutup_wr = cfg_wr_i && (cfg_offset_i == OFF_SHUTUP);

	// --------------------
	// register file
	// --------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			configured_o <= 1'b0;
			shutup_q <= 1'b0;
			card_base_o <= '0;
		end else begin
			// base write moves the card out of config space
			if (base_wr) begin
				card_base_o <= cfg_wdata_i;
				configured_o <= 1'b1;
			end
			if (shutup_wr)
				shutup_q <= 1'b1;
		end
	end

	// chain out, next slot may configure once we are done
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			cfgout_n_o <= 1'b1;
		else if (base_wr || shutup_wr)
			cfgout_n_o <= 1'b0;
		else
			cfgout_n_o <= !(configured_o || shutup_q);
	end

	// nibble read is combinational, the cycle fsm latches it
	assign cfg_rdata_o = cfg_rom_nibble(cfg_offset_i);

endmodule

`default_nettype wire

//--- logic/local_ram.sv
// requester must hold stb until ack; a dropped stb restarts the latency count
`default_nettype none
`timescale 1ns/10ps

`include "zorro_defs.svh"

module local_ram import zorro_bus_pkg::*; (
	input logic clk,
	input logic nIORST,
	input logic stb_i,
	input logic we_i,
	input logic [3:0] be_i,
	input ram_addr_t addr_i,
	input zdata_t wdata_i,
	output logic ack_o,
	output zdata_t rdata_o
);

	localparam int LAT_W = $clog2(`ZORRO_RAM_LATENCY + 1);
	localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(`ZORRO_RAM_LATENCY - 1);

	zdata_t mem [0:(1 << `ZORRO_RAM_AW)-1];
	logic [LAT_W-1:0] lat_q;
	// access happens on the clock that raises ack
	logic fire;

	assign fire = stb_i && !ack_o && (lat_q == LAT_LAST);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			ack_o <= 1'b0;
			lat_q <= '0;
		end else begin
			ack_o <= fire;
			if (!stb_i || ack_o || fire)
				lat_q <= '0;
			else
				lat_q <= lat_q + 1'b1;
		end
	end

	// byte lanes, bit 3 is D31..D24
	always_ff @(posedge clk) begin
		if (fire) begin
			if (we_i) begin
				for (int b = 0; b < 4; b++)
					if (be_i[b])
						mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
			end else begin
				rdata_o <= mem[addr_i];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/zorro_ram_top.sv
// logical 32-bit data with output enable; the pad ring does lane mapping and tristates
`default_nettype none
`timescale 1ns/10ps

module zorro_ram_top import zorro_bus_pkg::*, zorro_cfg_pkg::*; (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic doe_i,
	input zstrobe_t nds_i,
	input logic read_i,
	input logic [1:0] fc_i,
	input logic [23:0] ad_i,
	input logic [5:0] a_i,
	input logic cfgin_n_i,
	input logic nberr_i,
	input zdata_t data_i,
	output zdata_t data_o,
	output logic data_oe_o,
	output logic slave_n_o,
	output logic dtack_n_o,
	output logic cfgout_n_o
);

	// --------------------
	// stage wires
	// --------------------
	logic fcs_n;
	logic doe;
	zstrobe_t nds;
	zaddr_t addr;
	logic cfg_hit;
	logic card_hit;
	logic configured;
	card_base_t card_base;

	// request pairs
	logic ram_stb;
	logic ram_we;
	logic [3:0] ram_be;
	ram_addr_t ram_addr;
	zdata_t ram_wdata;
	logic ram_ack;
	zdata_t ram_rdata;
	logic cfg_wr;
	logic [15:0] cfg_wdata;
	cfg_offset_t cfg_offset;
	cfg_nibble_t cfg_rdata;

	bus_capture capture_i (
		.clk(clk), .nIORST(nIORST),
		.nfcs_i(nfcs_i), .doe_i(doe_i), .nds_i(nds_i),
		.fc_i(fc_i), .ad_i(ad_i), .a_i(a_i),
		.cfgin_n_i(cfgin_n_i), .configured_i(configured), .card_base_i(card_base),
		.fcs_n_o(fcs_n), .doe_o(doe), .nds_o(nds), .addr_o(addr),
		.cfg_hit_o(cfg_hit), .card_hit_o(card_hit)
	);

	cycle_ctrl ctrl_i (
		.clk(clk), .nIORST(nIORST),
		.fcs_n_i(fcs_n), .doe_i(doe), .nds_i(nds), .read_i(read_i), .nberr_i(nberr_i),
		.cfg_hit_i(cfg_hit), .card_hit_i(card_hit), .addr_i(addr), .data_i(data_i),
		.ram_ack_i(ram_ack), .ram_rdata_i(ram_rdata), .cfg_rdata_i(cfg_rdata),
		.slave_n_o(slave_n_o), .dtack_n_o(dtack_n_o), .data_o(data_o), .data_oe_o(data_oe_o),
		.ram_stb_o(ram_stb), .ram_we_o(ram_we), .ram_be_o(ram_be), .ram_addr_o(ram_addr),
		.ram_wdata_o(ram_wdata), .cfg_wr_o(cfg_wr), .cfg_wdata_o(cfg_wdata),
		.cfg_offset_o(cfg_offset)
	);

	autoconfig autoconfig_i (
		.clk(clk), .nIORST(nIORST),
		.cfg_wr_i(cfg_wr), .cfg_offset_i(cfg_offset), .cfg_wdata_i(cfg_wdata),
		.cfg_rdata_o(cfg_rdata), .configured_o(configured), .card_base_o(card_base),
		.cfgout_n_o(cfgout_n_o)
	);

	local_ram ram_i (
		.clk(clk), .nIORST(nIORST),
		.stb_i(ram_stb), .we_i(ram_we), .be_i(ram_be), .addr_i(ram_addr),
		.wdata_i(ram_wdata), .ack_o(ram_ack), .rdata_o(ram_rdata)
	);

endmodule

`default_nettype wire

//--- bench/zorro_ram_asserts.sv
// pin-level protocol checks only; a timeout shows as DTACK rising while SLAVE is still low
`default_nettype none
`timescale 1ns/10ps

module zorro_ram_asserts (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic read_i,
	input logic nberr_i,
	input logic slave_n_o,
	input logic dtack_n_o,
	input logic data_oe_o,
	input logic cfgout_n_o
);

	int fail_cnt = 0;
	logic dtack_q;
	// set once DTACK drops out on its own, cleared by the master ending the cycle
	logic timed_out_q;

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			dtack_q <= 1'b1;
			timed_out_q <= 1'b0;
		end else begin
			dtack_q <= dtack_n_o;
			if (nfcs_i)
				timed_out_q <= 1'b0;
			else if (dtack_n_o && !dtack_q && !slave_n_o)
				timed_out_q <= 1'b1;
		end
	end

	// --------------------
	// properties
	// --------------------
	// acknowledge only inside a claimed cycle
	dtack_needs_slave: assert property (@(posedge clk) disable iff (!nIORST)
		$fell(dtack_n_o) |-> !slave_n_o)
		else begin
			$error("dtack_n_o fell while slave_n_o was high");
			fail_cnt++;
		end

	// data drive on claimed reads only, and never during bus error
	oe_read_only: assert property (@(posedge clk) disable iff (!nIORST)
		data_oe_o |-> (read_i && nberr_i && !slave_n_o))
		else begin
			$error("data_oe_o high outside a claimed read or with nberr_i low");
			fail_cnt++;
		end

	dtack_parked: assert property (@(posedge clk) disable iff (!nIORST)
		timed_out_q |-> dtack_n_o)
		else begin
			$error("dtack_n_o asserted again after a timeout");
			fail_cnt++;
		end

	// first clock out of reset
	reset_idle: assert property (@(posedge clk)
		$rose(nIORST) |-> (slave_n_o && dtack_n_o && cfgout_n_o && !data_oe_o))
		else begin
			$error("outputs active after reset");
			fail_cnt++;
		end

endmodule

bind zorro_ram_top zorro_ram_asserts asserts_i (
	.clk(clk), .nIORST(nIORST), .nfcs_i(nfcs_i), .read_i(read_i), .nberr_i(nberr_i),
	.slave_n_o(slave_n_o), .dtack_n_o(dtack_n_o), .data_oe_o(data_oe_o),
	.cfgout_n_o(cfgout_n_o)
);

`default_nettype wire

//--- bench/zorro_ram_tb.sv
// single full cycles; the master holds address, fc and read for the whole cycle, card at 4000_0000
`default_nettype none
`timescale 1ns/10ps

`include "zorro_defs.svh"

module zorro_ram_tb;

	localparam logic [31:0] CARD_BASE = 32'h4000_0000;
	localparam int SLAVE_WAIT = 12;
	localparam int DTACK_WAIT = 40;
	localparam int RELEASE_WAIT = 8;
	localparam int POOL = 16;

	logic clk;
	logic nIORST;
	logic nfcs_i;
	logic doe_i;
	logic [3:0] nds_i;
	logic read_i;
	logic [1:0] fc_i;
	logic [23:0] ad_i;
	logic [5:0] a_i;
	logic cfgin_n_i;
	logic nberr_i;
	logic [31:0] data_i;
	logic [31:0] data_o;
	logic data_oe_o;
	logic slave_n_o;
	logic dtack_n_o;
	logic cfgout_n_o;

	logic [15:0] lfsr_q;
	// shadow of the pool words, word i sits at ram index {i, 6'h05}
	logic [31:0] shadow [0:POOL-1];
	int data_errs;
	int proto_errs;

	zorro_ram_top dut_i (
		.clk(clk), .nIORST(nIORST), .nfcs_i(nfcs_i), .doe_i(doe_i), .nds_i(nds_i),
		.read_i(read_i), .fc_i(fc_i), .ad_i(ad_i), .a_i(a_i), .cfgin_n_i(cfgin_n_i),
		.nberr_i(nberr_i), .data_i(data_i), .data_o(data_o), .data_oe_o(data_oe_o),
		.slave_n_o(slave_n_o), .dtack_n_o(dtack_n_o), .cfgout_n_o(cfgout_n_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------
	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic fb;
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// bytes as read from config space, type plain and the rest inverted
	function automatic logic [7:0] rom_byte(input int idx);
		case (idx)
			0: return 8'h82;
			1: return 8'hC3;
			2: return 8'hCF;
			4: return 8'hF0;
			5: return 8'hE1;
			9: return 8'hFE;
			default: return 8'hFF;
		endcase
	endfunction

	// contiguous byte enables, bit 3 is the top byte
	function automatic logic [3:0] strobe_mask(input int pick);
		case (pick % 10)
			0: return 4'b0001;
			1: return 4'b0010;
			2: return 4'b0100;
			3: return 4'b1000;
			4: return 4'b0011;
			5: return 4'b0110;
			6: return 4'b1100;
			7: return 4'b0111;
			8: return 4'b1110;
			default: return 4'b1111;
		endcase
	endfunction

	// random upper bits land on a mirror of the same ram word
	task automatic card_addr(input int i, output logic [31:0] addr);
		logic [31:0] v;
		v = take_bits(14);
		addr = CARD_BASE | (v[13:0] << 12) | ({i[3:0], 6'h05} << 2);
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] data_o: got %h, expected %h", got, exp);
			data_errs++;
		end
	endtask

	// --------------------
	// bus master
	// --------------------
	task automatic bus_cycle(input logic [31:0] addr, input logic [1:0] fc, input logic rd,
			input logic [31:0] wdata, input logic [3:0] nds, input logic hold,
			output logic responded, output logic [31:0] rdata);
		int n;
		@(negedge clk);
		ad_i = addr[31:8];
		a_i = addr[7:2];
		fc_i = fc;
		read_i = rd;
		nfcs_i = 1'b0;
		rdata = 'x;
		n = 0;
		while (slave_n_o && n < SLAVE_WAIT) begin
			@(negedge clk);
			n++;
		end
		responded = !slave_n_o;
		if (responded) begin
			doe_i = 1'b1;
			if (!rd) begin
				data_i = wdata;
				nds_i = nds;
			end
			n = 0;
			while (dtack_n_o && n < DTACK_WAIT) begin
				@(negedge clk);
				n++;
			end
			if (dtack_n_o) begin
				$display("no DTACK for the cycle at %h", addr);
				proto_errs++;
			end else if (rd) begin
				rdata = data_o;
				if (data_oe_o !== nberr_i) begin
					$display("[FAIL] data_oe_o: got %h, expected %h", data_oe_o, nberr_i);
					data_errs++;
				end
			end
			// master keeps nfcs low past the acknowledge
			if (hold && !dtack_n_o) begin
				n = 0;
				while (!dtack_n_o && n < `ZORRO_DTACK_TIMEOUT + 8) begin
					@(negedge clk);
					n++;
				end
				if (!dtack_n_o || n > `ZORRO_DTACK_TIMEOUT + 2) begin
					$display("DTACK still asserted %0d clocks into a stuck cycle", n);
					proto_errs++;
				end
				repeat (10) @(negedge clk);
			end
		end
		nfcs_i = 1'b1;
		doe_i = 1'b0;
		nds_i = 4'hF;
		n = 0;
		while ((!slave_n_o || !dtack_n_o) && n < RELEASE_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (!slave_n_o || !dtack_n_o) begin
			$display("bus not released after the cycle at %h", addr);
			proto_errs++;
		end
		repeat (2) @(negedge clk);
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin
		logic ok;
		logic [31:0] rd;
		logic [31:0] addr;
		logic [31:0] v;
		logic [3:0] mask;
		int total;
		lfsr_q = 16'd34748;
		data_errs = 0;
		proto_errs = 0;
		nIORST = 1'b0;
		nfcs_i = 1'b1;
		doe_i = 1'b0;
		nds_i = 4'hF;
		read_i = 1'b1;
		fc_i = 2'b01;
		ad_i = '0;
		a_i = '0;
		cfgin_n_i = 1'b0;
		nberr_i = 1'b1;
		data_i = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		nIORST = 1'b1;

		// rom reads, both nibble halves, listed and unlisted registers
		for (int half = 0; half < 2; half++) begin
			for (int idx = 0; idx < 16; idx++) begin
				addr = 32'hFF00_0000 | (half << 8) | (idx << 2);
				bus_cycle(addr, 2'b01, 1'b1, '0, 4'hF, 1'b0, ok, rd);
				v = {24'h0, rom_byte(idx)};
				if (!ok) begin
					$display("no slave response to the config read at %h", addr);
					proto_errs++;
				end else if (half == 1) begin
					check_word(rd, {v[3:0], 28'hFFF_FFFF});
				end else begin
					check_word(rd, {v[7:4], 28'hFFF_FFFF});
				end
			end
		end

		// unconfigured card ignores card space
		// base is still zero out of reset, so this address matches the compare bits
		bus_cycle(32'h0000_0000, 2'b01, 1'b1, '0, 4'hF, 1'b0, ok, rd);
		if (ok) begin
			$display("slave answered card space before configuration");
			proto_errs++;
		end
		if (cfgout_n_o !== 1'b1) begin
			$display("[FAIL] cfgout_n_o: got %h, expected %h", cfgout_n_o, 1'b1);
			data_errs++;
		end
		bus_cycle(32'hFF00_0044, 2'b01, 1'b0, {CARD_BASE[31:16], 16'h0}, 4'h0, 1'b0, ok, rd);
		if (!ok) begin
			$display("no slave response to the base write");
			proto_errs++;
		end
		if (cfgout_n_o !== 1'b0) begin
			$display("[FAIL] cfgout_n_o: got %h, expected %h", cfgout_n_o, 1'b0);
			data_errs++;
		end
		bus_cycle(32'hFF00_0000, 2'b01, 1'b1, '0, 4'hF, 1'b0, ok, rd);
		if (ok) begin
			$display("config space still answers after configuration");
			proto_errs++;
		end

		// fill the pool, then random partial writes through mirrors
		for (int i = 0; i < POOL; i++) begin
			v = take_bits(32);
			shadow[i] = v;
			card_addr(i, addr);
			bus_cycle(addr, 2'b01, 1'b0, v, 4'h0, 1'b0, ok, rd);
		end
		for (int k = 0; k < 32; k++) begin
			addr = take_bits(4);
			v = take_bits(4);
			mask = strobe_mask(v);
			v = take_bits(32);
			for (int b = 0; b < 4; b++)
				if (mask[b])
					shadow[addr[3:0]][b*8 +: 8] = v[b*8 +: 8];
			card_addr(addr[3:0], addr);
			bus_cycle(addr, 2'b01, 1'b0, v, ~mask, 1'b0, ok, rd);
			if (!ok) begin
				$display("no slave response to the card write at %h", addr);
				proto_errs++;
			end
		end
		for (int i = 0; i < POOL; i++) begin
			card_addr(i, addr);
			bus_cycle(addr, 2'b01, 1'b1, '0, 4'hF, 1'b0, ok, rd);
			if (!ok) begin
				$display("no slave response to the card read at %h", addr);
				proto_errs++;
			end else begin
				check_word(rd, shadow[i]);
			end
		end

		// only fc 01 and 10 are claimed
		bus_cycle(CARD_BASE, 2'b00, 1'b1, '0, 4'hF, 1'b0, ok, rd);
		if (ok) begin
			$display("slave answered memory-space code 00");
			proto_errs++;
		end
		bus_cycle(CARD_BASE, 2'b11, 1'b1, '0, 4'hF, 1'b0, ok, rd);
		if (ok) begin
			$display("slave answered memory-space code 11");
			proto_errs++;
		end

		// stuck master, then a read under bus error
		card_addr(0, addr);
		bus_cycle(addr, 2'b10, 1'b1, '0, 4'hF, 1'b1, ok, rd);
		if (ok)
			check_word(rd, shadow[0]);
		nberr_i = 1'b0;
		card_addr(1, addr);
		bus_cycle(addr, 2'b01, 1'b1, '0, 4'hF, 1'b0, ok, rd);
		nberr_i = 1'b1;

		repeat (4) @(negedge clk);
		total = data_errs + proto_errs + dut_i.asserts_i.fail_cnt;
		$display("errors: data %0d, protocol %0d, assertions %0d",
			data_errs, proto_errs, dut_i.asserts_i.fail_cnt);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- zorro_ram.f
+incdir+logic
logic/zorro_bus_pkg.sv
logic/zorro_cfg_pkg.sv
logic/bus_capture.sv
logic/cycle_ctrl.sv
logic/autoconfig.sv
logic/local_ram.sv
logic/zorro_ram_top.sv
bench/zorro_ram_asserts.sv
bench/zorro_ram_tb.sv

//--- Bender.yml
package:
  name: zorro_ram

sources:
  - include_dirs:
      - logic
    files:
      - logic/zorro_bus_pkg.sv
      - logic/zorro_cfg_pkg.sv
      - logic/bus_capture.sv
      - logic/cycle_ctrl.sv
      - logic/autoconfig.sv
      - logic/local_ram.sv
      - logic/zorro_ram_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/zorro_ram_asserts.sv
      - bench/zorro_ram_tb.sv
